//--- dv/video_stimulus.txt
# W reg value, R reg expected cpu_do, P line frames to wait
# one record per line, every field in hex
R 40 00
R 47 fc
R 41 80
R 4a ff
R 44 00
W 43 05
R 43 05
W 42 0c
W 45 14
R 45 14
W 41 40
R 41 c0
W 40 91
R 40 91
P 10 02
P 14 01
W 43 a3
W 42 37
W 40 89
P 5a 01
P 00 01
W 47 1b
P 30 01
W 41 10
P 8f 02
W 40 88
P 22 01
W 40 00
R 44 00

//--- list.f
src/video_pkg.sv
src/lcd_control.sv
src/lcd_timing.sv
src/bg_fetch.sv
src/bg_pixel_out.sv
src/video_top.sv
dv/video_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the background video testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module video_tb -o video_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
./obj_dir/video_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "^SIMULATION PASSED$" sim.log; then
	exit 0
fi
exit 1

//--- dv/video_tb.sv
// background video testbench: clock, vram model, stimulus file player and per-line checks
`timescale 1ns/100ps
`default_nettype none

module video_tb;

	logic        clk_reg;
	logic        reset;
	logic        reg_sel;
	logic        reg_wr;
	logic [7:0]  cpu_addr;
	logic [7:0]  cpu_di;
	logic [7:0]  cpu_do;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	logic        irq;
	logic        vblank_irq;
	logic [1:0]  mode;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data = 8'h00;

	logic [7:0]  vram [0:8191];
	// register values as last written from the stimulus file
	logic [7:0]  tb_lcdc;
	logic [7:0]  tb_stat;
	logic [7:0]  tb_scy;
	logic [7:0]  tb_scx;
	logic [7:0]  tb_lyc;
	logic [7:0]  tb_bgp;
	int          errors;
	int          checks;
	logic        aborted;

	video_top #(.PIXEL_W(2)) dut_i (
		.clk_reg(clk_reg), .reset(reset), .reg_sel(reg_sel), .reg_wr(reg_wr),
		.cpu_addr(cpu_addr), .cpu_di(cpu_di), .cpu_do(cpu_do), .lcd_on(lcd_on),
		.lcd_clkena(lcd_clkena), .lcd_data(lcd_data), .irq(irq), .vblank_irq(vblank_irq),
		.mode(mode), .vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data)
	);

	initial begin
		clk_reg = 1'b0;
		forever #50 clk_reg = ~clk_reg;
	end

	// vram answers one clock after the address
	always @(posedge clk_reg) begin
		vram_data <= vram[vram_addr];
	end

	// ------------------------------
	// reference model
	// ------------------------------
	// maps hold their own low address byte, tile data is scrambled
	function automatic logic [7:0] vram_fill(input logic [12:0] addr);
		if (addr >= 13'h1800)
			return addr[7:0];
		return addr[7:0] ^ 8'h5a;
	endfunction

	function automatic logic [1:0] bg_shade(input logic [7:0] x, input logic [7:0] ly);
		logic [7:0]  bx;
		logic [7:0]  by;
		logic [7:0]  tile;
		logic [12:0] map_a;
		logic [12:0] dat_a;
		logic [2:0]  bit_n;
		logic [1:0]  idx;

		bx    = tb_scx + x;
		by    = ly + tb_scy;
		map_a = {2'b11, tb_lcdc[3], by[7:3], bx[7:3]};
		tile  = vram[map_a];
		// signed tile numbers sit in the upper half when lcdc bit 4 is clear
		dat_a = {(tb_lcdc[4] ? 1'b0 : ~tile[7]), tile, by[2:0], 1'b0};
		bit_n = 3'd7 - bx[2:0];
		idx   = {vram[dat_a | 13'd1][bit_n], vram[dat_a][bit_n]};
		if (!tb_lcdc[0])
			return 2'b00;
		// bgp holds four shades, colour 0 in the low bits
		case (idx)
			2'd0: return tb_bgp[1:0];
			2'd1: return tb_bgp[3:2];
			2'd2: return tb_bgp[5:4];
			default: return tb_bgp[7:6];
		endcase
	endfunction

	// ------------------------------
	// cpu bus tasks
	// ------------------------------
	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk_reg);
		reg_sel  = 1'b1;
		reg_wr   = 1'b1;
		cpu_addr = addr;
		cpu_di   = data;
		@(negedge clk_reg);
		reg_wr   = 1'b0;
		case (addr)
			8'h40: tb_lcdc = data;
			8'h41: tb_stat = data;
			8'h42: tb_scy = data;
			8'h43: tb_scx = data;
			8'h45: tb_lyc = data;
			8'h47: tb_bgp = data;
			default: ;
		endcase
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [7:0] expected);
		@(negedge clk_reg);
		reg_sel  = 1'b1;
		reg_wr   = 1'b0;
		cpu_addr = addr;
		#1;
		checks++;
		assert (cpu_do === expected) else begin
			errors++;
			$display("error cpu_do at addr %h: got %h expected %h", addr, cpu_do, expected);
		end
	endtask

	// LY then STAT, both within one low clock phase
	task automatic sample_status(output logic [7:0] ly, output logic [7:0] stat);
		@(negedge clk_reg);
		reg_sel  = 1'b1;
		reg_wr   = 1'b0;
		cpu_addr = 8'h44;
		#1 ly = cpu_do;
		cpu_addr = 8'h41;
		#1 stat = cpu_do;
	endtask

	// ------------------------------
	// frame watcher and line capture
	// ------------------------------
	task automatic check_line(input logic [7:0] line, input logic [7:0] frames);
		logic [7:0] ly;
		logic [7:0] ly_prev;
		logic [7:0] stat;
		logic [1:0] px [0:159];
		logic [1:0] want;
		logic [1:0] want_mode;
		logic       frame_armed;
		logic       line_full;
		logic       collecting;
		logic       done;
		logic       addr_ok;
		logic       pos_ok;
		int         pulses;
		int         changes;
		int         strobes;
		int         lyc_hits;
		int         ticks;
		int         limit;
		int         dot;

		frame_armed = 1'b0;
		line_full   = 1'b0;
		collecting  = 1'b0;
		done        = 1'b0;
		pos_ok      = 1'b0;
		pulses      = 0;
		changes     = 0;
		strobes     = 0;
		lyc_hits    = 0;
		ticks       = 0;
		dot         = 0;
		limit       = (int'(frames) + 3) * 456 * 154;
		sample_status(ly_prev, stat);
		while (!done && ticks < limit) begin
			sample_status(ly, stat);
			ticks++;
			// LY moves on dot 0, so the dot is known after the first change
			if (ly != ly_prev) begin
				dot    = 0;
				pos_ok = 1'b1;
			end else begin
				dot++;
			end
			if (ly >= 8'd144)
				want_mode = 2'd1;
			else if (dot < 80)
				want_mode = 2'd2;
			else if (dot < 256)
				want_mode = 2'd3;
			else
				want_mode = 2'd0;
			checks++;
			assert (lcd_on === tb_lcdc[7]) else begin
				errors++;
				$display("error lcd_on: got %h expected %h", lcd_on, tb_lcdc[7]);
			end
			if (pos_ok) begin
				checks++;
				assert (mode === want_mode) else begin
					errors++;
					$display("error mode at LY %h dot %h: got %h expected %h",
						ly, dot, mode, want_mode);
				end
			end
			// whole vblank reports mode 1
			if (ly >= 8'd144) begin
				checks++;
				assert (stat[1:0] == 2'd1) else begin
					errors++;
					$display("error STAT mode at LY %h: got %h expected 1", ly, stat[1:0]);
				end
			end
			if (irq) begin
				checks++;
				assert (tb_stat[5] || tb_stat[3] || (tb_stat[4] && ly == 8'd144)
					|| (tb_stat[6] && ly == tb_lyc)) else begin
					errors++;
					$display("irq pulsed on line %0d with no enabled STAT source", ly);
				end
				if (tb_stat[6] && ly == tb_lyc)
					lyc_hits++;
			end
			// map select and tile data half follow LCDC
			if (vram_rd) begin
				checks++;
				if (vram_addr >= 13'h1800)
					addr_ok = vram_addr[10] == tb_lcdc[3];
				else
					addr_ok = vram_addr[12] == (!tb_lcdc[4] && !vram_addr[11]);
				assert (addr_ok) else begin
					errors++;
					$display("error vram_addr: got %h with LCDC %h", vram_addr, tb_lcdc);
				end
				if (pos_ok) begin
					checks++;
					assert (want_mode == 2'd3) else begin
						errors++;
						$display("error vram_rd at LY %h dot %h: got 1 expected 0", ly, dot);
					end
				end
			end
			if (lcd_clkena) begin
				if (collecting && strobes < 160)
					px[8'(strobes)] = lcd_data;
				strobes++;
			end
			if (ly != ly_prev) begin
				changes++;
				if (line_full && ly_prev < 8'd144) begin
					checks++;
					assert (strobes == 160) else begin
						errors++;
						$display("error lcd_clkena count on line %h: got %h expected %h",
							ly_prev, strobes, 160);
					end
				end
				if (collecting) begin
					for (int x = 0; x < 160; x++) begin
						want = bg_shade(8'(x), line);
						checks++;
						assert (px[8'(x)] === want) else begin
							errors++;
							$display("error lcd_data line %h x %h: got %h expected %h",
								line, x, px[8'(x)], want);
						end
					end
					done = 1'b1;
				end else if (pulses >= int'(frames) && ly == line) begin
					collecting = 1'b1;
				end
				strobes   = 0;
				line_full = 1'b1;
			end
			// 144 back to 144 is one full frame of LY values
			if (vblank_irq) begin
				// only the vblank source can raise irq on this clock
				checks++;
				assert (irq === tb_stat[4]) else begin
					errors++;
					$display("error irq at vblank_irq: got %h expected %h", irq, tb_stat[4]);
				end
				if (frame_armed) begin
					checks++;
					assert (changes == 154) else begin
						errors++;
						$display("error LY changes between vblank_irq pulses: got %h expected %h",
							changes, 154);
					end
				end
				changes     = 0;
				frame_armed = 1'b1;
				pulses++;
			end
			ly_prev = ly;
		end
		if (!done) begin
			errors++;
			aborted = 1'b1;
			$display("timeout waiting for line %0d after %0d frames", line, frames);
		end
		if (tb_stat[6] && frames >= 8'd2) begin
			checks++;
			assert (lyc_hits > 0) else begin
				errors++;
				$display("no irq pulse seen on the LYC line %0d", tb_lyc);
			end
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int         fd;
		int         code;
		int         n;
		string      line_s;
		logic [7:0] kind;
		logic [7:0] a;
		logic [7:0] b;

		errors   = 0;
		checks   = 0;
		aborted  = 1'b0;
		reset    = 1'b1;
		reg_sel  = 1'b0;
		reg_wr   = 1'b0;
		cpu_addr = 8'h00;
		cpu_di   = 8'h00;
		tb_lcdc  = 8'h00;
		tb_stat  = 8'h00;
		tb_scy   = 8'h00;
		tb_scx   = 8'h00;
		tb_lyc   = 8'h00;
		tb_bgp   = 8'hfc;
		for (int i = 0; i < 8192; i++)
			vram[13'(i)] = vram_fill(13'(i));
		repeat (10) @(negedge clk_reg);
		reset = 1'b0;
		checks++;
		assert (!irq && !vblank_irq && !lcd_clkena && !vram_rd && !lcd_on && mode == 2'd0)
		else begin
			errors++;
			$display("error outputs after reset: irq %h vblank_irq %h lcd_clkena %h vram_rd %h",
				irq, vblank_irq, lcd_clkena, vram_rd);
			$display("error outputs after reset: lcd_on %h mode %h", lcd_on, mode);
		end
		fd = $fopen("dv/video_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file dv/video_stimulus.txt");
		end else begin
			code = $fgets(line_s, fd);
			while (!aborted && code != 0) begin
				// comment lines stop the scan after the first field
				n = $sscanf(line_s, "%c %h %h", kind, a, b);
				if (n == 3) begin
					case (kind)
						"W": write_reg(a, b);
						"R": read_check(a, b);
						"P": check_line(a, b);
						default: begin
							errors++;
							$display("unknown record kind in stimulus line: %s", line_s);
						end
					endcase
				end
				code = $fgets(line_s, fd);
			end
			$fclose(fd);
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/video_top.sv
// background video top: register block, timing, fetch and pixel stages
`timescale 1ns/100ps
`default_nettype none

module video_top #(
	parameter int PIXEL_W = 2
) (
	input  wire                   clk_reg,
	input  wire                   reset,
	// cpu register bus
	input  wire                   reg_sel,
	input  wire                   reg_wr,
	input  wire [7:0]             cpu_addr,
	input  wire [7:0]             cpu_di,
	output wire [7:0]             cpu_do,
	// lcd side
	output wire                   lcd_on,
	output wire                   lcd_clkena,
	output wire [PIXEL_W-1:0]     lcd_data,
	output wire                   irq,
	output wire                   vblank_irq,
	output wire [1:0]             mode,
	// vram port
	output wire                   vram_rd,
	output video_pkg::vram_addr_u vram_addr,
	input  wire [7:0]             vram_data
);

	// register values
	wire [7:0] lcdc;
	wire [7:0] scx;
	wire [7:0] scy;
	wire [7:0] bgp;
	// beam position and per-line scroll
	wire [8:0] h_cnt;
	wire [7:0] v_cnt;
	wire       line_start;
	wire [7:0] scx_l;
	wire [7:0] scy_l;
	// fetch to pixel stage
	wire       tile_load;
	wire [7:0] tile_lo;
	wire [7:0] tile_hi;

	assign lcd_on = lcdc[7];

	lcd_control u_control (
		.clk_reg(clk_reg), .reset(reset),
		.reg_sel(reg_sel), .reg_wr(reg_wr), .cpu_addr(cpu_addr), .cpu_di(cpu_di),
		.h_cnt(h_cnt), .v_cnt(v_cnt), .mode(mode),
		.cpu_do(cpu_do), .lcdc(lcdc), .scx(scx), .scy(scy), .bgp(bgp),
		.irq(irq), .vblank_irq(vblank_irq)
	);

	lcd_timing u_timing (
		.clk_reg(clk_reg), .reset(reset), .lcd_on(lcdc[7]), .scx(scx), .scy(scy),
		.h_cnt(h_cnt), .v_cnt(v_cnt), .mode(mode), .line_start(line_start),
		.scx_l(scx_l), .scy_l(scy_l)
	);

	bg_fetch u_fetch (
		.clk_reg(clk_reg), .reset(reset), .lcdc(lcdc), .h_cnt(h_cnt), .v_cnt(v_cnt),
		.line_start(line_start), .scx_l(scx_l), .scy_l(scy_l), .vram_data(vram_data),
		.vram_rd(vram_rd), .vram_addr(vram_addr),
		.tile_load(tile_load), .tile_lo(tile_lo), .tile_hi(tile_hi)
	);

	bg_pixel_out #(.PIXEL_W(PIXEL_W)) u_pixel (
		.clk_reg(clk_reg), .reset(reset), .lcdc(lcdc), .v_cnt(v_cnt), .scx_l(scx_l),
		.line_start(line_start), .tile_load(tile_load), .tile_lo(tile_lo),
		.tile_hi(tile_hi), .bgp(bgp),
		.lcd_clkena(lcd_clkena), .lcd_data(lcd_data)
	);

endmodule

`default_nettype wire

//--- src/bg_pixel_out.sv
// background pixel output: plane shifters, fine scroll skip and bgp palette
`timescale 1ns/100ps
`default_nettype none

module bg_pixel_out #(
	parameter int PIXEL_W = 2
) (
	input  wire                clk_reg,
	input  wire                reset,
	input  wire [7:0]          lcdc,
	input  wire [7:0]          v_cnt,
	input  wire [7:0]          scx_l,
	input  wire                line_start,
	input  wire                tile_load,
	input  wire [7:0]          tile_lo,
	input  wire [7:0]          tile_hi,
	input  wire [7:0]          bgp,
	output logic               lcd_clkena,
	output logic [PIXEL_W-1:0] lcd_data
);
	import video_pkg::*;

	logic [7:0]         sh_lo;
	logic [7:0]         sh_hi;
	logic               run;
	logic [2:0]         skip;
	logic [7:0]         px_cnt;
	logic [1:0]         px_idx;
	logic               px_valid;
	logic [PIXEL_W-1:0] shade;

	// on a load dot the fresh tile msb goes out directly
	assign px_idx   = tile_load ? {tile_hi[7], tile_lo[7]} : {sh_hi[7], sh_lo[7]};
	assign px_valid = tile_load || run;
	// bg disabled shows colour 0 as shade 0
	assign shade    = lcdc[0] ? bgp[{px_idx, 1'b0} +: PIXEL_W] : '0;

	// ------------------------------
	// plane shifters, msb first
	// ------------------------------
	always_ff @(posedge clk_reg) begin
		if (tile_load) begin
			sh_lo <= {tile_lo[6:0], 1'b0};
			sh_hi <= {tile_hi[6:0], 1'b0};
		end else begin
			sh_lo <= {sh_lo[6:0], 1'b0};
			sh_hi <= {sh_hi[6:0], 1'b0};
		end
	end

	// skip scx[2:0] pixels, then emit one screen line
	always_ff @(posedge clk_reg) begin
		if (reset || !lcdc[7]) begin
			run        <= 1'b0;
			skip       <= 3'd0;
			px_cnt     <= 8'd0;
			lcd_clkena <= 1'b0;
		end else begin
			lcd_clkena <= 1'b0;
			if (line_start) begin
				run    <= 1'b0;
				skip   <= scx_l[2:0];
				px_cnt <= 8'd0;
			end else if (px_valid && ({1'b0, v_cnt} < VIS_LINES)) begin
				run <= 1'b1;
				if (skip != 3'd0) begin
					skip <= skip - 3'd1;
				end else if ({1'b0, px_cnt} != SCREEN_W) begin
					lcd_clkena <= 1'b1;
					px_cnt     <= px_cnt + 8'd1;
				end
			end
		end
	end

	// shade lines up with lcd_clkena
	always_ff @(posedge clk_reg) begin
		lcd_data <= shade;
	end

endmodule

`default_nettype wire

//--- src/bg_fetch.sv
// background fetch: tile map and tile data reads from vram, eight dots per tile
`timescale 1ns/100ps
`default_nettype none

module bg_fetch (
	input  wire                     clk_reg,
	input  wire                     reset,
	input  wire [7:0]               lcdc,
	input  wire [8:0]               h_cnt,
	input  wire [7:0]               v_cnt,
	input  wire                     line_start,
	input  wire [7:0]               scx_l,
	input  wire [7:0]               scy_l,
	input  wire [7:0]               vram_data,
	output logic                    vram_rd,
	output video_pkg::vram_addr_u   vram_addr,
	output logic                    tile_load,
	output logic [7:0]              tile_lo,
	output logic [7:0]              tile_hi
);
	import video_pkg::*;

	// end of the last fetch slot, dot 248
	localparam logic [8:0] FETCH_END = OAM_DOTS + 9'(FETCH_TILES * 8);

	logic       fetch_on;
	logic [1:0] phase;
	logic [7:0] bg_line;
	logic [4:0] tile_row;
	logic [4:0] tile_col;
	logic [7:0] tile_num;

	// background line inside the 256x256 map
	assign bg_line  = v_cnt + scy_l;
	// 0 map, 1 plane 0, 2 plane 1, 3 idle
	assign phase    = h_cnt[2:1];
	assign fetch_on = lcdc[7] && ({1'b0, v_cnt} < VIS_LINES)
		&& (h_cnt >= OAM_DOTS) && (h_cnt < FETCH_END);

	assign vram_rd   = fetch_on && (phase != 2'd3);
	assign tile_load = fetch_on && (h_cnt[2:0] == 3'd7);

	// ------------------------------
	// vram address build
	// ------------------------------
	always_comb begin
		vram_addr = '0;
		if (phase == 2'd0) begin
			vram_addr.map.area    = 2'b11;
			vram_addr.map.map_sel = lcdc[3];
			vram_addr.map.row     = tile_row;
			vram_addr.map.col     = tile_col;
		end else begin
			// lcdc[4] low means signed tile numbers based at 9000
			vram_addr.data.half  = lcdc[4] ? 1'b0 : ~tile_num[7];
			vram_addr.data.tile  = tile_num;
			vram_addr.data.line  = bg_line[2:0];
			vram_addr.data.plane = h_cnt[2];
		end
	end

	// map position, column wraps at 32 tiles
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			tile_row <= 5'd0;
			tile_col <= 5'd0;
		end else if (line_start) begin
			tile_row <= bg_line[7:3];
			tile_col <= scx_l[7:3];
		end else if (tile_load) begin
			tile_col <= tile_col + 5'd1;
		end
	end

	// data arrives on the second dot of each read pair
	always_ff @(posedge clk_reg) begin
		if (fetch_on && h_cnt[0]) begin
			case (phase)
				2'd0: tile_num <= vram_data;
				2'd1: tile_lo  <= vram_data;
				2'd2: tile_hi  <= vram_data;
				default: ;
			endcase
		end
	end

	// reads must stay inside the mode 3 window decoded by lcd_timing
	a_rd_draw: assert property (@(posedge clk_reg) disable iff (reset)
		vram_rd |-> lcdc[7] && ({1'b0, v_cnt} < VIS_LINES)
			&& (h_cnt >= OAM_DOTS) && (h_cnt < DRAW_END));

endmodule

`default_nettype wire

//--- src/lcd_timing.sv
// lcd timing: dot and line counters, mode decode and per-line scroll latch
`timescale 1ns/100ps
`default_nettype none

module lcd_timing (
	input  wire        clk_reg,
	input  wire        reset,
	input  wire        lcd_on,
	input  wire [7:0]  scx,
	input  wire [7:0]  scy,
	output logic [8:0] h_cnt,
	output logic [7:0] v_cnt,
	output logic [1:0] mode,
	output logic       line_start,
	output logic [7:0] scx_l,
	output logic [7:0] scy_l
);
	import video_pkg::*;

	logic [8:0] v_ext;
	logic       v_vis;
	logic       latch_dot;

	assign v_ext     = {1'b0, v_cnt};
	assign v_vis     = v_ext < VIS_LINES;
	// two dots before drawing starts
	assign latch_dot = h_cnt == OAM_DOTS - 9'd2;

	// ------------------------------
	// dot / line counters
	// ------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset || !lcd_on) begin
			// display off parks the beam at the top left
			h_cnt <= 9'd0;
			v_cnt <= 8'd0;
		end else if (h_cnt == LINE_DOTS - 9'd1) begin
			h_cnt <= 9'd0;
			if (v_ext == FRAME_LINES - 9'd1)
				v_cnt <= 8'd0;
			else
				v_cnt <= v_cnt + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// mode decode, vblank wins over the horizontal phases
	always_comb begin
		if (!lcd_on)
			mode = MODE_HBLANK;
		else if (!v_vis)
			mode = MODE_VBLANK;
		else if (h_cnt < OAM_DOTS)
			mode = MODE_OAM;
		else if (h_cnt < DRAW_END)
			mode = MODE_DRAW;
		else
			mode = MODE_HBLANK;
	end

	// ------------------------------
	// scroll latch and line strobe
	// ------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			scx_l      <= 8'h00;
			scy_l      <= 8'h00;
			line_start <= 1'b0;
		end else begin
			// scroll stays frozen for the rest of the line
			if (latch_dot) begin
				scx_l <= scx;
				scy_l <= scy;
			end
			// high at dot 79, right after the latch
			line_start <= lcd_on && latch_dot && v_vis;
		end
	end

	a_h_range: assert property (@(posedge clk_reg) disable iff (reset)
		h_cnt < LINE_DOTS);

endmodule

`default_nettype wire

//--- src/lcd_control.sv
// lcd register block: cpu visible registers, read mux and stat/vblank interrupts
`timescale 1ns/100ps
`default_nettype none

module lcd_control (
	input  wire        clk_reg,
	input  wire        reset,
	input  wire        reg_sel,
	input  wire        reg_wr,
	input  wire [7:0]  cpu_addr,
	input  wire [7:0]  cpu_di,
	input  wire [8:0]  h_cnt,
	input  wire [7:0]  v_cnt,
	input  wire [1:0]  mode,
	output logic [7:0] cpu_do,
	output logic [7:0] lcdc,
	output logic [7:0] scx,
	output logic [7:0] scy,
	output logic [7:0] bgp,
	output logic       irq,
	output logic       vblank_irq
);
	import video_pkg::*;

	// stat interrupt enables, stat bits 6..3
	logic [3:0] stat_ie;
	logic [7:0] lyc;
	logic       wr_en;
	logic       lyc_match;
	logic       line_begin;
	logic       vblank_begin;
	logic       hblank_begin;

	assign wr_en = reg_sel && reg_wr;

	// comparator only runs while the display is on
	assign lyc_match = lcdc[7] && (v_cnt == lyc);

	// ------------------------------
	// register writes
	// ------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			lcdc    <= 8'h00;
			stat_ie <= 4'h0;
			scy     <= 8'h00;
			scx     <= 8'h00;
			lyc     <= 8'h00;
			bgp     <= 8'hfc;
		end else if (wr_en) begin
			case (cpu_addr)
				REG_LCDC: lcdc    <= cpu_di;
				REG_STAT: stat_ie <= cpu_di[6:3];
				REG_SCY:  scy     <= cpu_di;
				REG_SCX:  scx     <= cpu_di;
				REG_LYC:  lyc     <= cpu_di;
				REG_BGP:  bgp     <= cpu_di;
				// LY is read only
				default: ;
			endcase
		end
	end

	// read mux, combinational from the address
	always_comb begin
		case (cpu_addr)
			REG_LCDC: cpu_do = lcdc;
			REG_STAT: cpu_do = {1'b1, stat_ie, lyc_match, mode};
			REG_SCY:  cpu_do = scy;
			REG_SCX:  cpu_do = scx;
			REG_LY:   cpu_do = v_cnt;
			REG_LYC:  cpu_do = lyc;
			REG_BGP:  cpu_do = bgp;
			default:  cpu_do = 8'hff;
		endcase
	end

	// ------------------------------
	// interrupt events
	// ------------------------------
	assign line_begin   = lcdc[7] && (h_cnt == 9'd0);
	// last dot of the last visible line
	assign vblank_begin = lcdc[7] && (h_cnt == LINE_DOTS - 9'd1)
		&& ({1'b0, v_cnt} == VIS_LINES - 9'd1);
	assign hblank_begin = lcdc[7] && (h_cnt == DRAW_END) && ({1'b0, v_cnt} < VIS_LINES);

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			irq        <= 1'b0;
			vblank_irq <= 1'b0;
		end else begin
			irq <= (stat_ie[3] && line_begin && lyc_match)
				|| (stat_ie[2] && line_begin)
				|| (stat_ie[1] && vblank_begin)
				|| (stat_ie[0] && hblank_begin);
			vblank_irq <= vblank_begin;
		end
	end

	// each event matches a single dot, so the stat line never stretches
	a_irq_pulse: assert property (@(posedge clk_reg) disable iff (reset)
		irq |=> !irq);

	// pulse lands on the first clock of line 144
	a_vblank_mode: assert property (@(posedge clk_reg) disable iff (reset || !lcdc[7])
		vblank_irq |-> mode == MODE_VBLANK);

endmodule

`default_nettype wire

//--- src/video_pkg.sv
// video package: line/frame timing, cpu register map, lcd modes and vram address layout
`default_nettype none

package video_pkg;

	// ------------------------------
	// line and frame timing
	// ------------------------------
	localparam logic [8:0] LINE_DOTS   = 9'd456;
	localparam logic [8:0] OAM_DOTS    = 9'd80;
	localparam logic [8:0] DRAW_END    = 9'd256;
	localparam logic [8:0] VIS_LINES   = 9'd144;
	localparam logic [8:0] FRAME_LINES = 9'd154;
	localparam logic [8:0] SCREEN_W    = 9'd160;
	// one extra tile covers the fine scroll offset
	localparam int         FETCH_TILES = 21;

	// ------------------------------
	// cpu register map (ff40 page)
	// ------------------------------
	localparam logic [7:0] REG_LCDC = 8'h40;
	localparam logic [7:0] REG_STAT = 8'h41;
	localparam logic [7:0] REG_SCY  = 8'h42;
	localparam logic [7:0] REG_SCX  = 8'h43;
	localparam logic [7:0] REG_LY   = 8'h44;
	localparam logic [7:0] REG_LYC  = 8'h45;
	localparam logic [7:0] REG_BGP  = 8'h47;

	// lcd mode as seen in stat[1:0]
	localparam logic [1:0] MODE_HBLANK = 2'd0;
	localparam logic [1:0] MODE_VBLANK = 2'd1;
	localparam logic [1:0] MODE_OAM    = 2'd2;
	localparam logic [1:0] MODE_DRAW   = 2'd3;

	// vram word address, read either as a tile-map entry or as a tile-data byte
	typedef union packed {
		struct packed {
			logic [1:0] area;     // 2'b11 selects the map region at 1800
			logic       map_sel;
			logic [4:0] row;
			logic [4:0] col;
		} map;
		struct packed {
			logic       half;     // signed tile numbering lands in 0800-17ff
			logic [7:0] tile;
			logic [2:0] line;
			logic       plane;
		} data;
	} vram_addr_u;

endpackage

`default_nettype wire
